// File: include/timing_source_consts.svh
`ifndef TIMING_SOURCE_CONSTS_SVH
`define TIMING_SOURCE_CONSTS_SVH

// frame word and matrix geometry
`define WORD_W           24      // frame word, K flag travels beside it
`define NUM_ROWS         4
`define PIX_PER_ROW      4
`define NUM_PIX          16      // NUM_ROWS * PIX_PER_ROW

// threshold compare
`define VTH_W            10      // global threshold
`define VTHC_W           8       // per row trim
`define THRES_REF_START  650     // reference of pixel 0
`define THRES_REF_STEP   2       // reference falls by this per pixel

// link side
`define BUF_DEPTH        8       // word buffer entries, also the starting credits

// fixed words
`define IDLE_WORD        24'hbcfcfc  // K28.5 K28.7 K28.7 comma
`define TRAILER_TAG      8'hf0

`endif

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module tb_timing_source -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Simulation completed successfully$'; then
  exit 0
else
  exit 1
fi

// File: src/ctrl_pkg.sv
`default_nettype none
`include "timing_source_consts.svh"

package ctrl_pkg;

  // frame source select, 1 and 3 emit nothing
  typedef enum logic [1:0] {
    STD_FRAME  = 2'd0,
    TEST_FRAME = 2'd2
  } frame_mode_e;

  typedef logic [`NUM_ROWS-1:0][`VTHC_W-1:0] row_trim_t;        // trim per row
  typedef logic [$clog2(`BUF_DEPTH+1)-1:0]    credit_t;          // 0..BUF_DEPTH
  typedef logic [$clog2(`BUF_DEPTH)-1:0]      buf_ptr_t;         // buffer slot

endpackage

`default_nettype wire

// File: src/frame_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

module frame_arbiter import frame_pkg::*; import ctrl_pkg::*; (
  input  logic       clk_S,
  input  logic       reset,
  input  logic       credit_return,
  frame_if.arb       std_src,
  frame_if.arb       test_src,
  output logic       wr_en,
  output link_word_t wr_word
);

  logic    locked;     // frame in progress
  logic    owner;      // 0 std source, 1 test source
  logic    rr_next;    // preferred source for the next frame
  logic    pick;
  logic    pick_last;
  logic    have_credit;
  credit_t credits;    // free slots in link_tx

  // pick is fixed while a frame is locked
  always_comb begin
    if (locked)
      pick = owner;
    else if (std_src.req && test_src.req)
      pick = rr_next;
    else
      pick = test_src.req;
  end

  assign have_credit    = (credits != '0);
  assign std_src.grant  = locked && !owner;
  assign test_src.grant = locked && owner;
  assign std_src.take   = have_credit && !pick && std_src.req;
  assign test_src.take  = have_credit && pick && test_src.req;

  assign wr_en     = std_src.take || test_src.take;
  assign wr_word   = pick ? test_src.word : std_src.word;
  assign pick_last = pick ? test_src.last : std_src.last;

  always_ff @(posedge clk_S or posedge reset) begin
    if (reset) begin
      locked  <= 1'b0;
      owner   <= 1'b0;
      rr_next <= 1'b0;
      credits <= credit_t'(`BUF_DEPTH);
    end else begin
      if (wr_en) begin
        if (!locked) begin
          owner   <= pick;
          rr_next <= !pick;     // other source first next time
        end
        locked <= !pick_last;   // lock released with the last word
      end
      if (wr_en && !credit_return)
        credits <= credits - credit_t'(1);
      else if (!wr_en && credit_return)
        credits <= credits + credit_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: src/frame_if.sv
`timescale 1ns/1ps
`default_nettype none

// frame source to arbiter link
interface frame_if import frame_pkg::*; ();

  link_word_t word;   // word on offer, held until take
  logic       req;    // source has a word ready
  logic       last;   // word closes the frame
  logic       grant;  // frame locked to this source
  logic       take;   // one cycle, word consumed

  modport src (
    output word, req, last,
    input  grant, take
  );

  modport arb (
    input  word, req, last,
    output grant, take
  );

endinterface

`default_nettype wire

// File: src/frame_pkg.sv
`default_nettype none
`include "timing_source_consts.svh"

package frame_pkg;

  // header view, mode in the top bits
  typedef struct packed {
    logic [1:0] mode;
    logic [4:0] error;    // always zero here
    logic [9:0] bcid;     // bunch crossing at trigger
    logic [5:0] l0l1;     // trigger count
    logic       parity;   // xor over bcid, error, l0l1
  } header_view_t;

  typedef struct packed {
    logic [7:0] addr;     // pixel index
    logic       zero;
    logic [7:0] tot;
    logic [6:0] toa;
  } hit_view_t;

  typedef struct packed {
    logic [7:0]            tag;       // TRAILER_TAG
    logic [7:0]            hit_cnt;
    logic [`WORD_W-17:0]   reserved;  // old crc byte, now zero
  } trailer_view_t;

  // one 24 bit frame word, decoded by position in the frame
  typedef union packed {
    header_view_t  hdr;
    hit_view_t     hit;
    trailer_view_t trl;
  } frame_word_t;

  typedef struct packed {
    logic        k;       // comma flag for the 8b/10b encoder
    frame_word_t word;
  } link_word_t;

endpackage

`default_nettype wire

// File: src/hit_frame_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

module hit_frame_gen import frame_pkg::*; import ctrl_pkg::*; (
  input  logic                 clk_S,
  input  logic                 reset,
  input  logic                 en,
  input  frame_mode_e          mode,
  input  logic                 trig,
  input  frame_word_t          header,
  input  logic [`VTH_W-1:0]    vth,
  input  row_trim_t            vthc,
  input  logic [`NUM_ROWS-1:0] pixel_on,
  frame_if.src                 fr
);

  localparam int STEP_W = $clog2(`NUM_PIX + 4);
  localparam int PIX_W  = $clog2(`NUM_PIX);
  localparam int ROW_W  = $clog2(`NUM_ROWS);
  localparam int SUM_W  = `VTH_W + 1;
  localparam logic [STEP_W-1:0] STEP_TRL  = STEP_W'(`NUM_PIX + 2);
  localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`NUM_PIX + 3);

  logic              busy;
  logic [STEP_W-1:0] step;       // 0 idle, 1 header, pixels, trailer, idle
  logic [7:0]        hit_cnt;
  logic [5:0]        tot_prbs;
  logic [4:0]        toa_prbs;
  logic [PIX_W-1:0]  pix;
  logic [ROW_W-1:0]  row;
  logic [SUM_W-1:0]  thres_sum, thres_ref;
  logic              on_pix, fire, advance;
  frame_word_t       hit_w, trl_w;

  ////////////////////////////////////////////////////////////////////////////
  // pixel under scan and its threshold compare
  assign pix       = PIX_W'(step - STEP_W'(2));
  assign row       = ROW_W'(pix / `PIX_PER_ROW);
  assign on_pix    = (step >= STEP_W'(2)) && (step < STEP_TRL);
  assign thres_sum = SUM_W'(vth) + SUM_W'(vthc[row]);
  assign thres_ref = SUM_W'(`THRES_REF_START - `THRES_REF_STEP * pix);  // falls per pixel
  assign fire      = on_pix && pixel_on[row] && (thres_sum <= thres_ref);

  always_comb begin
    hit_w.hit.addr = 8'(pix);
    hit_w.hit.zero = 1'b0;
    hit_w.hit.tot  = {2'b11, tot_prbs};
    hit_w.hit.toa  = {2'b11, toa_prbs};
    trl_w.trl.tag      = `TRAILER_TAG;
    trl_w.trl.hit_cnt  = hit_cnt;
    trl_w.trl.reserved = '0;      // crc byte dropped
  end

  ////////////////////////////////////////////////////////////////////////////
  // word on offer, idle words carry K
  always_comb begin
    fr.word.k    = 1'b0;
    fr.word.word = header;
    fr.last      = 1'b0;
    if (step == '0) begin
      fr.word.k    = 1'b1;
      fr.word.word = `IDLE_WORD;
    end else if (on_pix) begin
      fr.word.word = hit_w;
    end else if (step == STEP_TRL) begin
      fr.word.word = trl_w;
    end else if (step == STEP_LAST) begin
      fr.word.k    = 1'b1;
      fr.word.word = `IDLE_WORD;
      fr.last      = 1'b1;
    end
  end

  assign fr.req  = busy && (!on_pix || fire);            // quiet pixels offer nothing
  assign advance = busy && (fr.take || (on_pix && !fire)); // skip costs one cycle

  always_ff @(posedge clk_S or posedge reset) begin
    if (reset) begin
      busy     <= 1'b0;
      step     <= '0;
      hit_cnt  <= 8'd0;
      tot_prbs <= 6'd1;
      toa_prbs <= 5'd1;
    end else begin
      if (!busy) begin
        if (trig && en && mode == STD_FRAME) begin
          busy    <= 1'b1;
          step    <= '0;
          hit_cnt <= 8'd0;
        end
      end else if (advance) begin
        step <= step + STEP_W'(1);
        if (step == STEP_LAST)
          busy <= 1'b0;                // closing idle gone
      end
      if (fr.take && on_pix) begin       // one prbs step per hit written
        hit_cnt  <= hit_cnt + 8'd1;
        tot_prbs <= {tot_prbs[4:0], tot_prbs[5] ^ tot_prbs[0]};
        toa_prbs <= {toa_prbs[3:0], toa_prbs[4] ^ toa_prbs[0]};
      end
    end
  end

endmodule

`default_nettype wire

// File: src/link_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

module link_tx import frame_pkg::*; import ctrl_pkg::*; (
  input  logic       clk_S,
  input  logic       reset,
  input  logic       wr_en,
  input  link_word_t wr_word,
  input  logic       out_ready,
  output logic       credit_return,
  output logic       out_valid,
  output logic [7:0] out_data,
  output logic       char_is_k
);

  link_word_t mem [`BUF_DEPTH];   // word buffer
  buf_ptr_t   wr_ptr, rd_ptr;
  credit_t    fill;               // words held
  logic [1:0] byte_sel;           // byte of the head word, msb first
  link_word_t head;
  logic       pop;

  function automatic buf_ptr_t bump(input buf_ptr_t p);
    bump = (p == buf_ptr_t'(`BUF_DEPTH - 1)) ? '0 : p + buf_ptr_t'(1);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // byte serializer
  assign head      = mem[rd_ptr];
  assign out_valid = (fill != '0);
  assign char_is_k = head.k;        // same over all three bytes

  always_comb begin
    case (byte_sel)
      2'd0:    out_data = head.word[23:16];
      2'd1:    out_data = head.word[15:8];
      default: out_data = head.word[7:0];
    endcase
  end

  assign pop           = out_valid && out_ready && (byte_sel == 2'd2);
  assign credit_return = pop;       // slot free again

  always_ff @(posedge clk_S) begin
    if (wr_en)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge clk_S or posedge reset) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      byte_sel <= 2'd0;
    end else begin
      if (wr_en)
        wr_ptr <= bump(wr_ptr);
      if (pop)
        rd_ptr <= bump(rd_ptr);
      if (wr_en && !pop)
        fill <= fill + credit_t'(1);
      else if (!wr_en && pop)
        fill <= fill - credit_t'(1);
      if (out_valid && out_ready)
        byte_sel <= (byte_sel == 2'd2) ? 2'd0 : byte_sel + 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: src/test_frame_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

module test_frame_gen import frame_pkg::*; import ctrl_pkg::*; (
  input  logic        clk_S,
  input  logic        reset,
  input  logic        en,
  input  frame_mode_e mode,
  input  logic        trig,
  input  frame_word_t header,
  input  logic [7:0]  frame_data,
  frame_if.src        fr
);

  logic       busy;
  logic [1:0] seq;     // idle, header, data, idle

  always_comb begin
    fr.word.k    = 1'b0;
    fr.word.word = header;
    fr.last      = 1'b0;
    case (seq)
      2'd0: begin
        fr.word.k    = 1'b1;
        fr.word.word = `IDLE_WORD;
      end
      2'd1: fr.word.word = header;
      2'd2: fr.word.word = {3{frame_data}};   // config byte three times
      default: begin
        fr.word.k    = 1'b1;
        fr.word.word = `IDLE_WORD;
        fr.last      = 1'b1;
      end
    endcase
  end

  assign fr.req = busy;

  always_ff @(posedge clk_S or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      seq  <= 2'd0;
    end else if (!busy) begin
      if (trig && en && mode == TEST_FRAME) begin
        busy <= 1'b1;
        seq  <= 2'd0;
      end
    end else if (fr.take) begin
      seq <= seq + 2'd1;
      if (seq == 2'd3)
        busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/timing_source_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

module timing_source_top import ctrl_pkg::*; (
  input  logic                 clk_S,
  input  logic                 reset,
  input  logic                 en,
  input  frame_mode_e          mode,
  input  logic                 trigger,
  input  logic [`VTH_W-1:0]    vth,
  input  row_trim_t            vthc,
  input  logic [`NUM_ROWS-1:0] pixel_on,
  input  logic [7:0]           frame_data,
  input  logic                 out_ready,
  output logic                 out_valid,
  output logic [7:0]           out_data,
  output logic                 char_is_k
);

  logic                    trig;            // synchronized trigger
  frame_pkg::frame_word_t  header;
  logic                    wr_en, credit_return;
  frame_pkg::link_word_t   wr_word;

  frame_if std_if ();    // hit frames
  frame_if test_if ();   // test frames

  trigger_counters u_trig (.clk_S, .reset, .trigger, .mode, .trig, .header);

  hit_frame_gen u_hit (
    .clk_S, .reset, .en, .mode, .trig, .header,
    .vth, .vthc, .pixel_on, .fr(std_if.src)
  );

  test_frame_gen u_test (
    .clk_S, .reset, .en, .mode, .trig, .header, .frame_data, .fr(test_if.src)
  );

  frame_arbiter u_arb (
    .clk_S, .reset, .credit_return,
    .std_src(std_if.arb), .test_src(test_if.arb), .wr_en, .wr_word
  );

  link_tx u_link (
    .clk_S, .reset, .wr_en, .wr_word, .out_ready,
    .credit_return, .out_valid, .out_data, .char_is_k
  );

endmodule

`default_nettype wire

// File: src/trigger_counters.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_counters import frame_pkg::*; import ctrl_pkg::*; (
  input  logic        clk_S,
  input  logic        reset,
  input  logic        trigger,
  input  frame_mode_e mode,
  output logic        trig,
  output frame_word_t header
);

  logic       trig_r, trig_rr;   // two stage sync
  logic [9:0] bcid;
  logic [5:0] l0l1;
  logic [5:0] l0l1_next;
  frame_word_t hdr_next;

  assign trig      = trig_rr;
  assign l0l1_next = (l0l1 == 6'd63) ? 6'd0 : l0l1 + 6'd1;   // modulo 64

  // header carries the count after this trigger
  always_comb begin
    hdr_next.hdr.mode   = mode;
    hdr_next.hdr.error  = 5'd0;
    hdr_next.hdr.bcid   = bcid;
    hdr_next.hdr.l0l1   = l0l1_next;
    hdr_next.hdr.parity = ^{bcid, 5'd0, l0l1_next};
  end

  always_ff @(posedge clk_S or posedge reset) begin
    if (reset) begin
      trig_r  <= 1'b0;
      trig_rr <= 1'b0;
      bcid    <= 10'd0;
      l0l1    <= 6'd0;
    end else begin
      trig_r  <= trigger;
      trig_rr <= trig_r;
      bcid    <= (bcid == 10'd1023) ? 10'd0 : bcid + 10'd1;  // free running
      if (trig_rr)
        l0l1 <= l0l1_next;
    end
  end

  always_ff @(posedge clk_S) begin
    if (trig_rr)
      header <= hdr_next;    // latched once per trigger
  end

endmodule

`default_nettype wire

// File: tb/tb_timing_source.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

module tb_timing_source import frame_pkg::*, ctrl_pkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table, one row per trigger
  typedef struct packed {
    logic [1:0]           mode;       // 1 and 3 are silent modes
    logic                 en;
    logic [`VTH_W-1:0]    vth;
    row_trim_t            trims;      // row 3 in the top byte
    logic [`NUM_ROWS-1:0] rows_on;
    logic [7:0]           data;       // test frame byte
    logic [7:0]           stall_pct;  // chance of out_ready low
  } stim_row_t;

  localparam int NUM_STIM = 11;
  localparam stim_row_t STIM [NUM_STIM] = '{
    '{2'd0, 1'b1, 10'd600, 32'h00000000, 4'hf, 8'h00, 8'd0},   // every pixel fires
    '{2'd0, 1'b1, 10'd620, 32'h00000000, 4'hb, 8'h00, 8'd0},   // row 2 off
    '{2'd0, 1'b1, 10'd620, 32'h03001300, 4'hf, 8'h00, 8'd30},  // trims on rows 1 and 3
    '{2'd2, 1'b1, 10'd0,   32'h00000000, 4'hf, 8'ha5, 8'd0},   // test frame
    '{2'd0, 1'b0, 10'd600, 32'h00000000, 4'hf, 8'h00, 8'd0},   // disabled
    '{2'd1, 1'b1, 10'd600, 32'h00000000, 4'hf, 8'h00, 8'd0},   // silent mode
    '{2'd3, 1'b1, 10'd600, 32'h00000000, 4'hf, 8'h00, 8'd0},
    '{2'd0, 1'b1, 10'd640, 32'h00000000, 4'hf, 8'h00, 8'd50},  // first six pixels
    '{2'd2, 1'b1, 10'd0,   32'h00000000, 4'hf, 8'h3c, 8'd60},
    '{2'd0, 1'b1, 10'd0,   32'h00000000, 4'hf, 8'h00, 8'd70},  // heavy stalls
    '{2'd0, 1'b1, 10'd700, 32'h00000000, 4'hf, 8'h00, 8'd20}   // empty frame
  };

  // frame words plus margin, three bytes each, eight cycles a byte
  localparam int WATCHDOG_NS = (NUM_STIM * (`NUM_PIX + 4) * 3 * 8 + 16) * 10;

  logic                 clk_S = 1'b0;
  logic                 reset;
  logic                 en;
  frame_mode_e          mode;
  logic                 trigger;
  logic [`VTH_W-1:0]    vth;
  row_trim_t            vthc;
  logic [`NUM_ROWS-1:0] pixel_on;
  logic [7:0]           frame_data;
  logic                 out_ready;
  logic                 out_valid;
  logic [7:0]           out_data;
  logic                 char_is_k;

  int unsigned stall_pct;
  int          checks_failed;
  logic [5:0]  model_l0l1;      // own trigger count
  logic [5:0]  tot_state;       // own prbs copies
  logic [4:0]  toa_state;

  timing_source_top u_dut (
    .clk_S, .reset, .en, .mode, .trigger, .vth, .vthc, .pixel_on,
    .frame_data, .out_ready, .out_valid, .out_data, .char_is_k
  );

  always #5 clk_S = ~clk_S;     // 10 ns

  // random back-pressure
  always @(posedge clk_S) begin
    if (reset)
      out_ready <= 1'b1;
    else
      out_ready <= (($urandom % 100) >= stall_pct);
  end

  ////////////////////////////////////////////////////////////////////////////
  // failure path and compare tasks
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic fail_now(input string msg);
    checks_failed++;
    $display("ERROR at time %0d ns: %s", $time, msg);
    abort_run();
  endtask

  task automatic check_word(input link_word_t got, input link_word_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("%s: got k=%0b word=%06h, expected k=%0b word=%06h",
                         what, got.k, got.word, exp.k, exp.word));
  endtask

  task automatic check_header(input frame_word_t got, input logic [1:0] exp_mode,
                              input logic [5:0] exp_l0l1);
    if (got.hdr.mode !== exp_mode)
      fail_now($sformatf("header mode %0d, expected %0d", got.hdr.mode, exp_mode));
    if (got.hdr.error !== 5'd0)
      fail_now($sformatf("header error field %0h, expected 0", got.hdr.error));
    if (got.hdr.l0l1 !== exp_l0l1)
      fail_now($sformatf("header l0l1 %0d, expected %0d", got.hdr.l0l1, exp_l0l1));
    if (got.hdr.parity !== ^{got.hdr.bcid, got.hdr.error, got.hdr.l0l1})
      fail_now("header parity does not match its fields");
  endtask

  task automatic check_count(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      fail_now($sformatf("trailer hit count %0d, expected %0d", got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model pieces
  function automatic link_word_t idle_word();
    link_word_t w;
    w.k    = 1'b1;
    w.word = `IDLE_WORD;       // comma on both frame ends
    return w;
  endfunction

  function automatic logic pixel_fires(input stim_row_t r, input int p);
    int row;
    int sum;
    int ref_level;
    row       = p / `PIX_PER_ROW;
    sum       = int'(r.vth) + int'(r.trims[row]);
    ref_level = `THRES_REF_START - `THRES_REF_STEP * p;   // falling reference
    return r.rows_on[row] && (sum <= ref_level);
  endfunction

  // one word off the byte stream, sampled mid-cycle
  task automatic collect_word(output link_word_t w);
    logic [7:0] b [3];
    logic       k0;
    int         n;
    n  = 0;
    k0 = 1'b0;
    while (n < 3) begin
      @(negedge clk_S);
      if (out_valid && out_ready) begin
        b[n] = out_data;
        if (n == 0)
          k0 = char_is_k;
        else if (char_is_k !== k0)
          fail_now("K flag changed inside a word");
        n++;
      end
    end
    w.k    = k0;
    w.word = {b[0], b[1], b[2]};   // msb first
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk_S);
      if (out_valid)
        fail_now("output byte outside an expected frame");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // apply one table row and check its frame
  task automatic run_row(input stim_row_t r);
    link_word_t got;
    link_word_t exp;
    logic [7:0] hits;
    @(posedge clk_S);
    mode       <= frame_mode_e'(r.mode);
    en         <= r.en;
    vth        <= r.vth;
    vthc       <= r.trims;
    pixel_on   <= r.rows_on;
    frame_data <= r.data;
    stall_pct  <= 32'(r.stall_pct);
    trigger    <= 1'b1;
    @(posedge clk_S);
    trigger    <= 1'b0;
    model_l0l1 = model_l0l1 + 6'd1;   // counted even when silent
    if (!r.en || r.mode == 2'd1 || r.mode == 2'd3) begin
      expect_quiet(40);
    end else begin
      collect_word(got);
      check_word(got, idle_word(), "opening idle");
      collect_word(got);
      if (got.k)
        fail_now("header word carries the K flag");
      check_header(got.word, r.mode, model_l0l1);
      if (r.mode == 2'd2) begin
        exp.k    = 1'b0;
        exp.word = {3{r.data}};
        collect_word(got);
        check_word(got, exp, "test data word");
      end else begin
        hits = 8'd0;
        for (int p = 0; p < `NUM_PIX; p++) begin
          if (pixel_fires(r, p)) begin
            exp.k              = 1'b0;
            exp.word.hit.addr  = 8'(p);
            exp.word.hit.zero  = 1'b0;
            exp.word.hit.tot   = {2'b11, tot_state};
            exp.word.hit.toa   = {2'b11, toa_state};
            collect_word(got);
            check_word(got, exp, $sformatf("hit word for pixel %0d", p));
            tot_state = {tot_state[4:0], tot_state[5] ^ tot_state[0]};
            toa_state = {toa_state[3:0], toa_state[4] ^ toa_state[0]};
            hits      = hits + 8'd1;
          end
        end
        collect_word(got);
        check_count(got.word.trl.hit_cnt, hits);
        exp.k                 = 1'b0;
        exp.word.trl.tag      = `TRAILER_TAG;
        exp.word.trl.hit_cnt  = hits;
        exp.word.trl.reserved = 8'h00;     // no crc
        check_word(got, exp, "trailer");
      end
      collect_word(got);
      check_word(got, idle_word(), "closing idle");
      expect_quiet(20);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h1e999bd6));
    reset         = 1'b1;
    en            = 1'b0;
    mode          = STD_FRAME;
    trigger       = 1'b0;
    vth           = '0;
    vthc          = '0;
    pixel_on      = '0;
    frame_data    = 8'h00;
    out_ready     = 1'b1;
    stall_pct     = 0;
    checks_failed = 0;
    model_l0l1    = 6'd0;
    tot_state     = 6'd1;     // both prbs seeded to one
    toa_state     = 5'd1;
    repeat (16) @(posedge clk_S);
    reset <= 1'b0;
    for (int i = 0; i < NUM_STIM; i++)
      run_row(STIM[i]);
    if (checks_failed == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort_run();
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: frames did not complete within %0d ns", WATCHDOG_NS);
    abort_run();
  end

endmodule

`default_nettype wire

// File: tb/timing_source_assertions.sv
`timescale 1ns/1ps
`default_nettype none
`include "timing_source_consts.svh"

// protocol checks, one copy on the arbiter and one on link_tx
module timing_source_assertions import ctrl_pkg::*; (
  input wire logic       clk_S,
  input wire logic       reset,
  input wire logic       take,       // word moved into the buffer
  input wire credit_t    level,      // credits or free buffer slots
  input wire logic       out_valid,
  input wire logic       out_ready,
  input wire logic [7:0] out_data,
  input wire logic       char_is_k
);

  // a write needs a free slot
  a_take_needs_credit: assert property (
    @(posedge clk_S) disable iff (reset) take |-> (level != '0)
  ) else $error("take issued with no credit left");

  // stalled byte must not move
  a_hold_on_stall: assert property (
    @(posedge clk_S) disable iff (reset)
    (out_valid && !out_ready) |=> ($stable(out_data) && $stable(char_is_k))
  ) else $error("output byte changed during a stall");

  a_level_bound: assert property (
    @(posedge clk_S) disable iff (reset) level <= credit_t'(`BUF_DEPTH)
  ) else $error("credit or fill count above buffer depth");

endmodule

// arbiter side, no byte stream here
bind frame_arbiter timing_source_assertions u_arb_chk (
  .clk_S, .reset, .take(wr_en), .level(credits),
  .out_valid(1'b0), .out_ready(1'b1), .out_data(8'h00), .char_is_k(1'b0)
);

// free buffer slots mirror the arbiter credits
bind link_tx timing_source_assertions u_link_chk (
  .clk_S, .reset, .take(wr_en), .level(credit_t'(`BUF_DEPTH) - fill),
  .out_valid, .out_ready, .out_data, .char_is_k
);

`default_nettype wire

// File: verilog.f
+incdir+include
src/frame_pkg.sv
src/ctrl_pkg.sv
src/frame_if.sv
src/trigger_counters.sv
src/hit_frame_gen.sv
src/test_frame_gen.sv
src/frame_arbiter.sv
src/link_tx.sv
src/timing_source_top.sv
tb/timing_source_assertions.sv
tb/tb_timing_source.sv
